//--- Bender.yml
package:
  name: simple_scheduler

sources:
  - sched_pkg.sv
  - slot_keeper.sv
  - core_selector.sv
  - ctrl_decoder.sv
  - desc_allocator.sv
  - rx_port_ctrl.sv
  - simple_scheduler.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_simple_scheduler.sv

//--- core_selector.sv
module core_selector #(
  parameter int CORE_COUNT = 16,
  parameter int SLOT_COUNT = 8,
  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT + 1),
  localparam int CORE_ID_WIDTH = $clog2(CORE_COUNT)
) (
  input  logic [CORE_COUNT*SLOT_WIDTH-1:0] counts,
  input  logic [CORE_COUNT-1:0]            eligible,
  output logic [CORE_ID_WIDTH-1:0]         best_core,
  output logic                             best_valid
);

  localparam int LEVELS = $clog2(CORE_COUNT);
  localparam int LEAVES = 1 << LEVELS;
  localparam int NODES  = 2 * LEAVES - 1;

  // Heap-ordered tree, node k has children 2k+1 and 2k+2
  logic [SLOT_WIDTH-1:0]    node_val [NODES];
  logic [CORE_ID_WIDTH-1:0] node_idx [NODES];
  logic                     node_vld [NODES];

  for (genvar i = 0; i < LEAVES; i++) begin : g_leaf
    if (i < CORE_COUNT) begin : g_core
      assign node_vld[LEAVES-1+i] = eligible[i] && (counts[i*SLOT_WIDTH +: SLOT_WIDTH] != '0);
      assign node_val[LEAVES-1+i] = eligible[i] ? counts[i*SLOT_WIDTH +: SLOT_WIDTH] : '0;
    end else begin : g_pad
      assign node_vld[LEAVES-1+i] = 1'b0;
      assign node_val[LEAVES-1+i] = '0;
    end
    assign node_idx[LEAVES-1+i] = CORE_ID_WIDTH'(i);
  end

  for (genvar k = 0; k < LEAVES - 1; k++) begin : g_node
    logic take_left;

    // Left subtree holds the lower indices, so it keeps ties
    assign take_left = node_vld[2*k+1] &&
                       (!node_vld[2*k+2] || (node_val[2*k+1] >= node_val[2*k+2]));
    assign node_val[k] = take_left ? node_val[2*k+1] : node_val[2*k+2];
    assign node_idx[k] = take_left ? node_idx[2*k+1] : node_idx[2*k+2];
    assign node_vld[k] = node_vld[2*k+1] || node_vld[2*k+2];
  end

  assign best_core  = node_idx[0];
  assign best_valid = node_vld[0];

endmodule

//--- ctrl_decoder.sv
module ctrl_decoder #(
  parameter int CORE_COUNT     = 16,
  parameter int SLOT_COUNT     = 8,
  parameter int PKT_DONE_DEPTH = 8,
  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT + 1),
  localparam int CORE_ID_WIDTH = $clog2(CORE_COUNT),
  localparam int CTRL_WIDTH    = sched_pkg::MSG_TYPE_WIDTH + sched_pkg::DESC_WIDTH
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [CTRL_WIDTH-1:0]    ctrl_in_data,
  input  logic [CORE_ID_WIDTH-1:0] ctrl_in_src,
  input  logic                     ctrl_in_valid,
  output logic                     ctrl_in_ready,
  output logic [CORE_COUNT-1:0]    enq_strobe,
  output logic [CORE_COUNT-1:0]    init_strobe,
  output logic [SLOT_WIDTH-1:0]    slot_value,
  output logic [CTRL_WIDTH-1:0]    ctrl_out_data,
  output logic [CORE_ID_WIDTH-1:0] ctrl_out_dest,
  output logic                     ctrl_out_valid,
  input  logic                     ctrl_out_ready
);

  import sched_pkg::*;

  localparam int PTR_WIDTH  = (PKT_DONE_DEPTH > 1) ? $clog2(PKT_DONE_DEPTH) : 1;
  localparam int FILL_WIDTH = $clog2(PKT_DONE_DEPTH + 1);

  msg_type_e               msg_type;
  logic                    accept;
  logic                    fifo_push;
  logic                    fifo_pop;
  logic                    fifo_full;
  logic [PTR_WIDTH-1:0]    rd_ptr;
  logic [PTR_WIDTH-1:0]    wr_ptr;
  logic [FILL_WIDTH-1:0]   fill;
  logic [CORE_ID_WIDTH-1:0] fifo_src [PKT_DONE_DEPTH];
  logic [DESC_WIDTH-1:0]   fifo_desc [PKT_DONE_DEPTH];

  function automatic logic [PTR_WIDTH-1:0] ptr_inc(input logic [PTR_WIDTH-1:0] ptr);
    return (ptr == PTR_WIDTH'(PKT_DONE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign msg_type = msg_type_e'(ctrl_in_data[CTRL_WIDTH-1 -: MSG_TYPE_WIDTH]);

  // Only packet-done messages can be back-pressured, everything else is taken
  assign ctrl_in_ready = (msg_type == PKT_DONE) ? !fifo_full : 1'b1;
  assign accept        = ctrl_in_valid && ctrl_in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      enq_strobe  <= '0;
      init_strobe <= '0;
    end else begin
      for (int c = 0; c < CORE_COUNT; c++) begin
        enq_strobe[c]  <= accept && (msg_type == SLOT_RETURN) &&
                          (ctrl_in_src == CORE_ID_WIDTH'(c));
        init_strobe[c] <= accept && (msg_type == SLOT_INIT) &&
                          (ctrl_in_src == CORE_ID_WIDTH'(c));
      end
    end
  end

  always_ff @(posedge clk)
    slot_value <= ctrl_in_data[SLOT_FIELD_LSB +: SLOT_WIDTH];

  // Packet-done queue feeding the output register
  assign fifo_full = (fill == FILL_WIDTH'(PKT_DONE_DEPTH));
  assign fifo_push = accept && (msg_type == PKT_DONE);
  assign fifo_pop  = (fill != '0) && (!ctrl_out_valid || ctrl_out_ready);

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      fill   <= '0;
    end else begin
      if (fifo_push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (fifo_pop)
        rd_ptr <= ptr_inc(rd_ptr);
      fill <= fill + FILL_WIDTH'(fifo_push) - FILL_WIDTH'(fifo_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_push) begin
      fifo_src[wr_ptr]  <= ctrl_in_src;
      fifo_desc[wr_ptr] <= ctrl_in_data[DESC_WIDTH-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      ctrl_out_valid <= 1'b0;
    else if (fifo_pop)
      ctrl_out_valid <= 1'b1;
    else if (ctrl_out_ready)
      ctrl_out_valid <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (fifo_pop) begin
      ctrl_out_data <= {SEND_OUT, fifo_desc[rd_ptr]};
      ctrl_out_dest <= fifo_src[rd_ptr];
    end
  end

endmodule

//--- desc_allocator.sv
module desc_allocator #(
  parameter int INTERFACE_COUNT = 2,
  parameter int CORE_COUNT      = 16,
  parameter int SLOT_COUNT      = 8,
  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT + 1),
  localparam int CORE_ID_WIDTH = $clog2(CORE_COUNT),
  localparam int TAG_WIDTH     = (SLOT_WIDTH > sched_pkg::TAG_MIN_WIDTH) ?
                                 SLOT_WIDTH : sched_pkg::TAG_MIN_WIDTH,
  localparam int ID_TAG_WIDTH  = CORE_ID_WIDTH + TAG_WIDTH
) (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic [INTERFACE_COUNT-1:0]              desc_req,
  input  logic [CORE_ID_WIDTH-1:0]                best_core,
  input  logic                                    best_valid,
  input  logic [CORE_COUNT*SLOT_WIDTH-1:0]        head_slots,
  output logic [CORE_COUNT-1:0]                   slot_pop,
  output logic [INTERFACE_COUNT-1:0]              desc_loaded,
  output logic [INTERFACE_COUNT*ID_TAG_WIDTH-1:0] loaded_desc
);

  localparam int IF_WIDTH = (INTERFACE_COUNT > 1) ? $clog2(INTERFACE_COUNT) : 1;

  logic [IF_WIDTH-1:0]     rr_ptr;
  logic [IF_WIDTH-1:0]     grant_idx;
  logic                    grant_valid;
  logic [ID_TAG_WIDTH-1:0] new_desc;

  // Scan from the pointer, the closest requester wins
  always_comb begin
    int cand;
    grant_valid = 1'b0;
    grant_idx   = '0;
    for (int o = INTERFACE_COUNT - 1; o >= 0; o--) begin
      cand = (int'(rr_ptr) + o) % INTERFACE_COUNT;
      if (desc_req[cand]) begin
        grant_valid = best_valid;
        grant_idx   = IF_WIDTH'(cand);
      end
    end
  end

  assign new_desc    = {best_core, TAG_WIDTH'(head_slots[best_core*SLOT_WIDTH +: SLOT_WIDTH])};
  assign slot_pop    = CORE_COUNT'(grant_valid) << best_core;
  assign desc_loaded = INTERFACE_COUNT'(grant_valid) << grant_idx;

  always_ff @(posedge clk) begin
    if (rst)
      rr_ptr <= '0;
    else if (grant_valid)
      rr_ptr <= (grant_idx == IF_WIDTH'(INTERFACE_COUNT - 1)) ? '0 : grant_idx + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (grant_valid)
      loaded_desc[grant_idx*ID_TAG_WIDTH +: ID_TAG_WIDTH] <= new_desc;
  end

endmodule

//--- rx_port_ctrl.sv
module rx_port_ctrl #(
  parameter int CORE_COUNT = 16,
  parameter int SLOT_COUNT = 8,
  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT + 1),
  localparam int CORE_ID_WIDTH = $clog2(CORE_COUNT),
  localparam int TAG_WIDTH     = (SLOT_WIDTH > sched_pkg::TAG_MIN_WIDTH) ?
                                 SLOT_WIDTH : sched_pkg::TAG_MIN_WIDTH,
  localparam int ID_TAG_WIDTH  = CORE_ID_WIDTH + TAG_WIDTH
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    rx_tvalid,
  input  logic                    rx_tlast,
  output logic                    rx_tready,
  output logic                    data_tvalid,
  input  logic                    data_tready,
  output logic [ID_TAG_WIDTH-1:0] data_tdest,
  input  logic                    desc_loaded,
  input  logic [ID_TAG_WIDTH-1:0] loaded_desc,
  output logic                    desc_req
);

  import sched_pkg::*;

  port_state_e             state;
  logic [ID_TAG_WIDTH-1:0] pkt_desc;
  logic                    active;
  logic                    beat;
  logic                    last_beat;

  assign active      = (state != STALL);
  assign rx_tready   = data_tready && active;
  assign data_tvalid = rx_tvalid && active;
  assign beat        = rx_tvalid && rx_tready;
  assign last_beat   = beat && rx_tlast;

  // Next descriptor is fetched as soon as the current packet starts
  assign desc_req = (state == STALL) || (state == WAIT) || ((state == FIRST) && beat);

  assign data_tdest = (state == FIRST) ? loaded_desc : pkt_desc;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= STALL;
    end else begin
      case (state)
        STALL: begin
          if (desc_loaded)
            state <= FIRST;
        end
        FIRST: begin
          // A grant in the start cycle already covers the next packet
          if (last_beat)
            state <= desc_loaded ? FIRST : STALL;
          else if (beat)
            state <= desc_loaded ? MID : WAIT;
        end
        WAIT: begin
          if (desc_loaded && last_beat)
            state <= FIRST;
          else if (desc_loaded)
            state <= MID;
          else if (last_beat)
            state <= STALL;
        end
        MID: begin
          if (last_beat)
            state <= FIRST;
        end
        default: state <= STALL;
      endcase
    end
  end

  // Hold the packet's descriptor once the loaded register moves on
  always_ff @(posedge clk) begin
    if ((state == FIRST) && beat)
      pkt_desc <= loaded_desc;
  end

endmodule

//--- sched_pkg.sv
package sched_pkg;

  // Control word is {type, payload} with the type in the top bits
  localparam int MSG_TYPE_WIDTH = 4;
  localparam int DESC_WIDTH     = 32;

  // Slot number position inside slot-return and slot-init payloads
  localparam int SLOT_FIELD_LSB = 16;

  // Smallest tag field, slot numbers are zero-extended into it
  localparam int TAG_MIN_WIDTH  = 5;

  typedef enum logic [MSG_TYPE_WIDTH-1:0] {
    SLOT_RETURN = 4'd0,
    PKT_DONE    = 4'd1,
    CORE_MSG    = 4'd2,
    SLOT_INIT   = 4'd3
  } msg_type_e;

  // Outgoing packet-done messages reuse encoding 0
  localparam msg_type_e SEND_OUT = SLOT_RETURN;

  typedef enum logic [1:0] {
    STALL, // no descriptor, hold the port
    FIRST, // descriptor ready, waiting for a packet start
    WAIT,  // inside a packet, next descriptor not loaded yet
    MID    // inside a packet, next descriptor already loaded
  } port_state_e;

endpackage

//--- simple_scheduler.sv
module simple_scheduler #(
  parameter int INTERFACE_COUNT = 2,
  parameter int CORE_COUNT      = 16,
  parameter int SLOT_COUNT      = 8,
  parameter int DATA_WIDTH      = 64,
  parameter int PKT_DONE_DEPTH  = 8,
  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT + 1),
  localparam int CORE_ID_WIDTH = $clog2(CORE_COUNT),
  localparam int TAG_WIDTH     = (SLOT_WIDTH > sched_pkg::TAG_MIN_WIDTH) ?
                                 SLOT_WIDTH : sched_pkg::TAG_MIN_WIDTH,
  localparam int ID_TAG_WIDTH  = CORE_ID_WIDTH + TAG_WIDTH,
  localparam int STRB_WIDTH    = DATA_WIDTH / 8,
  localparam int PORT_WIDTH    = (INTERFACE_COUNT > 1) ? $clog2(INTERFACE_COUNT) : 1,
  localparam int CTRL_WIDTH    = sched_pkg::MSG_TYPE_WIDTH + sched_pkg::DESC_WIDTH
) (
  input  logic                                    clk,
  input  logic                                    rst,

  input  logic [INTERFACE_COUNT*DATA_WIDTH-1:0]   rx_tdata,
  input  logic [INTERFACE_COUNT*STRB_WIDTH-1:0]   rx_tkeep,
  input  logic [INTERFACE_COUNT-1:0]              rx_tvalid,
  output logic [INTERFACE_COUNT-1:0]              rx_tready,
  input  logic [INTERFACE_COUNT-1:0]              rx_tlast,

  output logic [INTERFACE_COUNT*DATA_WIDTH-1:0]   data_tdata,
  output logic [INTERFACE_COUNT*STRB_WIDTH-1:0]   data_tkeep,
  output logic [INTERFACE_COUNT*ID_TAG_WIDTH-1:0] data_tdest,
  output logic [INTERFACE_COUNT*PORT_WIDTH-1:0]   data_tuser,
  output logic [INTERFACE_COUNT-1:0]              data_tvalid,
  input  logic [INTERFACE_COUNT-1:0]              data_tready,
  output logic [INTERFACE_COUNT-1:0]              data_tlast,

  input  logic [CTRL_WIDTH-1:0]                   ctrl_in_data,
  input  logic [CORE_ID_WIDTH-1:0]                ctrl_in_src,
  input  logic                                    ctrl_in_valid,
  output logic                                    ctrl_in_ready,

  output logic [CTRL_WIDTH-1:0]                   ctrl_out_data,
  output logic [CORE_ID_WIDTH-1:0]                ctrl_out_dest,
  output logic                                    ctrl_out_valid,
  input  logic                                    ctrl_out_ready,

  input  logic [CORE_COUNT-1:0]                   income_cores
);

  logic [CORE_COUNT-1:0]                   enq_strobe;
  logic [CORE_COUNT-1:0]                   init_strobe;
  logic [SLOT_WIDTH-1:0]                   slot_value;
  logic [CORE_COUNT-1:0]                   slot_pop;
  logic [CORE_COUNT*SLOT_WIDTH-1:0]        head_slots;
  logic [CORE_COUNT-1:0]                   head_valid;
  logic [CORE_COUNT*SLOT_WIDTH-1:0]        counts;
  logic [CORE_ID_WIDTH-1:0]                best_core;
  logic                                    best_valid;
  logic [INTERFACE_COUNT-1:0]              desc_req;
  logic [INTERFACE_COUNT-1:0]              desc_loaded;
  logic [INTERFACE_COUNT*ID_TAG_WIDTH-1:0] loaded_desc;

  ctrl_decoder #(
    .CORE_COUNT     (CORE_COUNT),
    .SLOT_COUNT     (SLOT_COUNT),
    .PKT_DONE_DEPTH (PKT_DONE_DEPTH)
  ) i_ctrl_decoder (
    .clk            (clk),
    .rst            (rst),
    .ctrl_in_data   (ctrl_in_data),
    .ctrl_in_src    (ctrl_in_src),
    .ctrl_in_valid  (ctrl_in_valid),
    .ctrl_in_ready  (ctrl_in_ready),
    .enq_strobe     (enq_strobe),
    .init_strobe    (init_strobe),
    .slot_value     (slot_value),
    .ctrl_out_data  (ctrl_out_data),
    .ctrl_out_dest  (ctrl_out_dest),
    .ctrl_out_valid (ctrl_out_valid),
    .ctrl_out_ready (ctrl_out_ready)
  );

  for (genvar c = 0; c < CORE_COUNT; c++) begin : g_keeper
    slot_keeper #(
      .SLOT_COUNT (SLOT_COUNT)
    ) i_slot_keeper (
      .clk        (clk),
      .rst        (rst),
      .init_valid (init_strobe[c]),
      .enq_valid  (enq_strobe[c]),
      .slot_in    (slot_value),
      .pop        (slot_pop[c]),
      .head_slot  (head_slots[c*SLOT_WIDTH +: SLOT_WIDTH]),
      .head_valid (head_valid[c]),
      .count      (counts[c*SLOT_WIDTH +: SLOT_WIDTH])
    );
  end

  core_selector #(
    .CORE_COUNT (CORE_COUNT),
    .SLOT_COUNT (SLOT_COUNT)
  ) i_core_selector (
    .counts     (counts),
    .eligible   (income_cores & head_valid),
    .best_core  (best_core),
    .best_valid (best_valid)
  );

  desc_allocator #(
    .INTERFACE_COUNT (INTERFACE_COUNT),
    .CORE_COUNT      (CORE_COUNT),
    .SLOT_COUNT      (SLOT_COUNT)
  ) i_desc_allocator (
    .clk         (clk),
    .rst         (rst),
    .desc_req    (desc_req),
    .best_core   (best_core),
    .best_valid  (best_valid),
    .head_slots  (head_slots),
    .slot_pop    (slot_pop),
    .desc_loaded (desc_loaded),
    .loaded_desc (loaded_desc)
  );

  for (genvar p = 0; p < INTERFACE_COUNT; p++) begin : g_port
    rx_port_ctrl #(
      .CORE_COUNT (CORE_COUNT),
      .SLOT_COUNT (SLOT_COUNT)
    ) i_rx_port_ctrl (
      .clk         (clk),
      .rst         (rst),
      .rx_tvalid   (rx_tvalid[p]),
      .rx_tlast    (rx_tlast[p]),
      .rx_tready   (rx_tready[p]),
      .data_tvalid (data_tvalid[p]),
      .data_tready (data_tready[p]),
      .data_tdest  (data_tdest[p*ID_TAG_WIDTH +: ID_TAG_WIDTH]),
      .desc_loaded (desc_loaded[p]),
      .loaded_desc (loaded_desc[p*ID_TAG_WIDTH +: ID_TAG_WIDTH]),
      .desc_req    (desc_req[p])
    );

    // Stamp the receiving interface number
    assign data_tuser[p*PORT_WIDTH +: PORT_WIDTH] = PORT_WIDTH'(p);
  end

  assign data_tdata = rx_tdata;
  assign data_tkeep = rx_tkeep;
  assign data_tlast = rx_tlast;

endmodule

//--- slot_keeper.sv
module slot_keeper #(
  parameter int SLOT_COUNT = 8,
  localparam int SLOT_WIDTH = $clog2(SLOT_COUNT + 1)
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  init_valid,
  input  logic                  enq_valid,
  input  logic [SLOT_WIDTH-1:0] slot_in,
  input  logic                  pop,
  output logic [SLOT_WIDTH-1:0] head_slot,
  output logic                  head_valid,
  output logic [SLOT_WIDTH-1:0] count
);

  localparam int PTR_WIDTH = (SLOT_COUNT > 1) ? $clog2(SLOT_COUNT) : 1;

  logic [SLOT_WIDTH-1:0] slots [SLOT_COUNT];
  logic [PTR_WIDTH-1:0]  rd_ptr;
  logic [PTR_WIDTH-1:0]  wr_ptr;
  logic [SLOT_WIDTH-1:0] init_count;
  logic                  do_enq;
  logic                  do_pop;

  function automatic logic [PTR_WIDTH-1:0] ptr_inc(input logic [PTR_WIDTH-1:0] ptr);
    return (ptr == PTR_WIDTH'(SLOT_COUNT - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // An init larger than the buffer is clamped to a full buffer
  assign init_count = (slot_in > SLOT_WIDTH'(SLOT_COUNT)) ? SLOT_WIDTH'(SLOT_COUNT) : slot_in;

  assign do_enq     = enq_valid && (count != SLOT_WIDTH'(SLOT_COUNT));
  assign do_pop     = pop && head_valid;
  assign head_valid = (count != '0);
  assign head_slot  = slots[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (init_valid) begin
      rd_ptr <= '0;
      wr_ptr <= (init_count == SLOT_WIDTH'(SLOT_COUNT)) ? '0 : PTR_WIDTH'(init_count);
      count  <= init_count;
    end else begin
      if (do_enq)
        wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)
        rd_ptr <= ptr_inc(rd_ptr);
      count <= count + SLOT_WIDTH'(do_enq) - SLOT_WIDTH'(do_pop);
    end
  end

  // Init fills every entry with 1..SLOT_COUNT, only the first N count
  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int s = 0; s < SLOT_COUNT; s++)
        slots[s] <= SLOT_WIDTH'(s + 1);
    end else if (do_enq) begin
      slots[wr_ptr] <= slot_in;
    end
  end

endmodule

//--- tb.f
sched_pkg.sv
slot_keeper.sv
core_selector.sv
ctrl_decoder.sv
desc_allocator.sv
rx_port_ctrl.sv
simple_scheduler.sv
tb_clock_gen.sv
tb_simple_scheduler.sv

//--- tb_clock_gen.sv
module tb_clock_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  // Release just after an edge, like the rest of the stimulus
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule

//--- tb_simple_scheduler.sv
module tb_simple_scheduler;

  timeunit 1ns;
  timeprecision 100ps;

  import sched_pkg::*;

  localparam int IFS    = 2;
  localparam int CORES  = 4;
  localparam int SLOTS  = 8;
  localparam int DW     = 64;
  localparam int KW     = DW / 8;
  localparam int DESC_W = 7;
  localparam int CTRL_W = MSG_TYPE_WIDTH + DESC_WIDTH;
  localparam int CLK_PERIOD = 4;

  localparam int INIT_COUNTS [CORES] = '{3, 6, 4, 5};
  localparam int NUM_RETURNS   = 4;
  localparam int SEQ_PKTS      = 5;
  localparam int MASK_PKTS     = 3;
  localparam int PKTS_PER_PORT = 5;
  localparam int NUM_CTRL_MSGS = 16;
  localparam int TEST_ITEMS    = CORES + NUM_RETURNS + SEQ_PKTS + MASK_PKTS +
                                 IFS * PKTS_PER_PORT + NUM_CTRL_MSGS;

  logic                  clk;
  logic                  rst;
  logic [IFS*DW-1:0]     rx_tdata;
  logic [IFS*KW-1:0]     rx_tkeep;
  logic [IFS-1:0]        rx_tvalid;
  logic [IFS-1:0]        rx_tready;
  logic [IFS-1:0]        rx_tlast;
  logic [IFS*DW-1:0]     data_tdata;
  logic [IFS*KW-1:0]     data_tkeep;
  logic [IFS*DESC_W-1:0] data_tdest;
  logic [IFS-1:0]        data_tuser;
  logic [IFS-1:0]        data_tvalid;
  logic [IFS-1:0]        data_tready;
  logic [IFS-1:0]        data_tlast;
  logic [CTRL_W-1:0]     ctrl_in_data;
  logic [1:0]            ctrl_in_src;
  logic                  ctrl_in_valid;
  logic                  ctrl_in_ready;
  logic [CTRL_W-1:0]     ctrl_out_data;
  logic [1:0]            ctrl_out_dest;
  logic                  ctrl_out_valid;
  logic                  ctrl_out_ready;
  logic [CORES-1:0]      income_cores;

  // Reference model state
  int                    model_q [CORES][$];
  logic [CORES-1:0]      model_mask;
  logic [DESC_W-1:0]     prefetch [IFS];
  logic [DESC_W-1:0]     outstanding [$];
  logic [DESC_W-1:0]     used_desc [$];

  // Monitor state
  logic [DW+KW:0]        exp_beats [IFS][$];
  logic [DESC_W-1:0]     got_desc [IFS][$];
  logic                  in_pkt [IFS];
  logic [DESC_W-1:0]     cur_desc [IFS];
  logic [CTRL_W+1:0]     exp_ctrl [$];
  logic                  ctrl_stall_en;
  logic                  tready_stall_en;

  tb_clock_gen #(
    .PERIOD_NS    (CLK_PERIOD),
    .RESET_CYCLES (4)
  ) i_tb_clock_gen (
    .clk (clk),
    .rst (rst)
  );

  simple_scheduler #(
    .CORE_COUNT (CORES)
  ) i_simple_scheduler (
    .clk            (clk),
    .rst            (rst),
    .rx_tdata       (rx_tdata),
    .rx_tkeep       (rx_tkeep),
    .rx_tvalid      (rx_tvalid),
    .rx_tready      (rx_tready),
    .rx_tlast       (rx_tlast),
    .data_tdata     (data_tdata),
    .data_tkeep     (data_tkeep),
    .data_tdest     (data_tdest),
    .data_tuser     (data_tuser),
    .data_tvalid    (data_tvalid),
    .data_tready    (data_tready),
    .data_tlast     (data_tlast),
    .ctrl_in_data   (ctrl_in_data),
    .ctrl_in_src    (ctrl_in_src),
    .ctrl_in_valid  (ctrl_in_valid),
    .ctrl_in_ready  (ctrl_in_ready),
    .ctrl_out_data  (ctrl_out_data),
    .ctrl_out_dest  (ctrl_out_dest),
    .ctrl_out_valid (ctrl_out_valid),
    .ctrl_out_ready (ctrl_out_ready),
    .income_cores   (income_cores)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual)
      abort_run($sformatf("ERROR %s expected %0h actual %0h", name, expected, actual));
  endtask

  // Most free slots wins and the lowest index breaks a tie
  function automatic int pick_core(input logic [CORES-1:0] mask);
    int best;
    best = -1;
    for (int c = 0; c < CORES; c++) begin
      if (mask[c] && model_q[c].size() > 0) begin
        if (best < 0 || model_q[c].size() > model_q[best].size())
          best = c;
      end
    end
    return best;
  endfunction

  task automatic predict_pop(output logic [DESC_W-1:0] desc);
    int c;
    c = pick_core(model_mask);
    if (c < 0) begin
      desc = '0;
      abort_run("Reference model has no free slot left to hand out");
    end else begin
      desc = {2'(c), 5'(model_q[c].pop_front())};
    end
  endtask

  task automatic wait_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic send_ctrl(input msg_type_e kind, input int src, input logic [31:0] payload);
    ctrl_in_data  = {kind, payload};
    ctrl_in_src   = 2'(src);
    ctrl_in_valid = 1'b1;
    @(posedge clk);
    while (!ctrl_in_ready) @(posedge clk);
    #1;
    ctrl_in_valid = 1'b0;
  endtask

  // Keeper state settles two cycles after the message is taken
  task automatic init_core(input int c, input int n);
    send_ctrl(SLOT_INIT, c, 32'(n) << SLOT_FIELD_LSB);
    model_q[c].delete();
    for (int s = 1; s <= n && s <= SLOTS; s++)
      model_q[c].push_back(s);
    repeat (2) wait_cycle();
  endtask

  task automatic return_slot(input logic [DESC_W-1:0] desc);
    send_ctrl(SLOT_RETURN, int'(desc[6:5]), 32'(desc[4:0]) << SLOT_FIELD_LSB);
    if (model_q[desc[6:5]].size() < SLOTS)
      model_q[desc[6:5]].push_back(int'(desc[4:0]));
    repeat (2) wait_cycle();
  endtask

  task automatic send_packet(input int p, input int len);
    logic [DW-1:0] data;
    logic [KW-1:0] keep;
    logic          last;
    for (int b = 0; b < len; b++) begin
      data = {$urandom, $urandom};
      last = (b == len - 1);
      keep = last ? (8'hFF >> ($urandom % KW)) : 8'hFF;
      exp_beats[p].push_back({last, keep, data});
      rx_tdata[p*DW +: DW] = data;
      rx_tkeep[p*KW +: KW] = keep;
      rx_tlast[p]          = last;
      rx_tvalid[p]         = 1'b1;
      @(posedge clk);
      while (!rx_tready[p]) @(posedge clk);
      #1;
    end
    rx_tvalid[p] = 1'b0;
  endtask

  task automatic send_checked_packet(input int p);
    logic [DESC_W-1:0] expected;
    logic [DESC_W-1:0] seen;
    expected = prefetch[p];
    // Starting this packet fetches the next descriptor
    predict_pop(prefetch[p]);
    send_packet(p, 1 + ($urandom % 4));
    if (got_desc[p].size() == 0) begin
      abort_run($sformatf("Packet on interface %0d finished without being seen", p));
    end else begin
      seen = got_desc[p].pop_front();
      check("packet data_tdest", expected, seen);
      used_desc.push_back(seen);
    end
  endtask

  task automatic run_port(input int p);
    for (int k = 0; k < PKTS_PER_PORT; k++) begin
      repeat ($urandom % 3) wait_cycle();
      send_packet(p, 1 + ($urandom % 4));
    end
  endtask

  task automatic match_descriptors(input int p);
    logic [DESC_W-1:0] seen;
    int                found;
    check("packets seen on interface", PKTS_PER_PORT, got_desc[p].size());
    check("beats left over on interface", 0, exp_beats[p].size());
    while (got_desc[p].size() > 0) begin
      seen  = got_desc[p].pop_front();
      found = -1;
      foreach (outstanding[i])
        if (found < 0 && outstanding[i] == seen)
          found = i;
      if (found < 0)
        abort_run($sformatf("Descriptor %0h on interface %0d was not predicted or came twice",
                            seen, p));
      else
        outstanding.delete(found);
    end
  endtask

  task automatic drive_ready_stalls();
    forever begin
      @(posedge clk);
      #1;
      ctrl_out_ready = ctrl_stall_en ? (($urandom % 2) == 1) : 1'b1;
      for (int p = 0; p < IFS; p++)
        data_tready[p] = tready_stall_en ? (($urandom % 4) != 0) : 1'b1;
    end
  endtask

  task automatic check_beat(input int p);
    logic [DW+KW:0]    beat;
    logic [DESC_W-1:0] dest;
    dest = data_tdest[p*DESC_W +: DESC_W];
    if (exp_beats[p].size() == 0) begin
      abort_run($sformatf("Interface %0d forwarded a beat that was never sent", p));
    end else begin
      beat = exp_beats[p].pop_front();
      check("data_tdata", beat[DW-1:0], data_tdata[p*DW +: DW]);
      check("data_tkeep", beat[DW+KW-1:DW], data_tkeep[p*KW +: KW]);
      check("data_tlast", beat[DW+KW], data_tlast[p]);
      check("data_tuser", p, data_tuser[p]);
      if (!in_pkt[p])
        cur_desc[p] = dest;
      else
        check("data_tdest inside packet", cur_desc[p], dest);
      in_pkt[p] = !beat[DW+KW];
      if (beat[DW+KW])
        got_desc[p].push_back(cur_desc[p]);
    end
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      for (int p = 0; p < IFS; p++)
        if (data_tvalid[p] && data_tready[p])
          check_beat(p);
    end
  end

  always @(posedge clk) begin
    logic [CTRL_W+1:0] expected;
    if (!rst && ctrl_out_valid && ctrl_out_ready) begin
      if (exp_ctrl.size() == 0) begin
        abort_run("Control output sent a message that nobody asked for");
      end else begin
        expected = exp_ctrl.pop_front();
        check("ctrl_out_data", expected[CTRL_W-1:0], ctrl_out_data);
        check("ctrl_out_dest", expected[CTRL_W+1:CTRL_W], ctrl_out_dest);
      end
    end
  end

  initial begin
    #(200 * TEST_ITEMS * CLK_PERIOD);
    abort_run("Watchdog expired before the test sequence finished");
  end

  initial begin
    int                masked;
    int                src;
    logic [31:0]       payload;
    void'($urandom(32'h2fec9c22));
    rx_tdata        = '0;
    rx_tkeep        = '0;
    rx_tvalid       = '0;
    rx_tlast        = '0;
    data_tready     = '1;
    ctrl_in_data    = '0;
    ctrl_in_src     = '0;
    ctrl_in_valid   = 1'b0;
    ctrl_out_ready  = 1'b1;
    income_cores    = '0;
    model_mask      = '0;
    ctrl_stall_en   = 1'b0;
    tready_stall_en = 1'b0;
    for (int p = 0; p < IFS; p++)
      in_pkt[p] = 1'b0;
    fork
      drive_ready_stalls();
    join_none

    @(posedge clk);
    while (rst) @(posedge clk);
    #1;
    check("ctrl_out_valid after reset", 0, ctrl_out_valid);
    check("rx_tready after reset", 0, rx_tready);

    // Load every core while none is eligible yet
    for (int c = 0; c < CORES; c++)
      init_core(c, INIT_COUNTS[c]);
    check("rx_tready with no eligible core", 0, rx_tready);

    // Port 0 wins the first grant and port 1 the next
    income_cores = '1;
    model_mask   = '1;
    predict_pop(prefetch[0]);
    predict_pop(prefetch[1]);
    @(posedge clk);
    while (rx_tready != '1) @(posedge clk);
    #1;

    for (int i = 0; i < SEQ_PKTS; i++) begin
      send_checked_packet(0);
      if (i >= 1 && i <= NUM_RETURNS)
        return_slot(used_desc.pop_front());
    end

    // Drop the core that currently holds the most slots
    masked       = pick_core(model_mask);
    income_cores = ~(CORES'(1) << masked);
    model_mask   = income_cores;
    for (int i = 0; i < MASK_PKTS; i++)
      send_checked_packet(0);
    income_cores = '1;
    model_mask   = '1;

    // Packet-done messages under output stalls with every fourth one a core message
    ctrl_stall_en = 1'b1;
    for (int i = 0; i < NUM_CTRL_MSGS; i++) begin
      src     = $urandom % CORES;
      payload = $urandom;
      if (i % 4 == 3) begin
        send_ctrl(CORE_MSG, src, payload);
      end else begin
        exp_ctrl.push_back({2'(src), SEND_OUT, payload});
        send_ctrl(PKT_DONE, src, payload);
      end
    end
    while (exp_ctrl.size() != 0) wait_cycle();
    ctrl_stall_en = 1'b0;
    repeat (4) wait_cycle();
    check("ctrl_out_valid after drain", 0, ctrl_out_valid);

    // Pop order is global and only the port that gets each descriptor varies
    outstanding.push_back(prefetch[0]);
    outstanding.push_back(prefetch[1]);
    for (int k = 0; k < IFS * PKTS_PER_PORT; k++) begin
      predict_pop(prefetch[0]);
      outstanding.push_back(prefetch[0]);
    end
    tready_stall_en = 1'b1;
    fork
      run_port(0);
      run_port(1);
    join
    tready_stall_en = 1'b0;
    for (int p = 0; p < IFS; p++)
      match_descriptors(p);

    $display("TEST PASSED");
    $finish;
  end

endmodule
